// File: include/mips_ex_defs.svh
// sizing macros for the execute path: input buffer depth, output credits, data memory words
`ifndef MIPS_EX_DEFS_SVH
`define MIPS_EX_DEFS_SVH

// ##################################################
// input side
// ##################################################

// entries in the issue buffer, which is also the source's credit count after reset
`define IN_DEPTH 4

// ##################################################
// output side
// ##################################################

// credits granted by the sink after reset
`define OUT_CREDITS 2

// 32-bit words of data memory, indexed by address bits above the byte lanes
`define DMEM_WORDS 64

`endif

// File: verilog/mips_ex_pkg.sv
// package mips_ex_pkg: operation enums plus request, execute-result and writeback structs
package mips_ex_pkg;

    typedef enum logic [4:0] {
        OP_NOP,
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_NOR,
        OP_SLT,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_SLLV,
        OP_SRLV,
        OP_SRAV,
        OP_LU,
        OP_MUL,
        OP_MULT,
        OP_MFHI,
        OP_MFLO,
        OP_MTHI,
        OP_MTLO,
        OP_MOVN,
        OP_MOVZ,
        OP_LB,
        OP_LH,
        OP_LW,
        OP_SB,
        OP_SH,
        OP_SW
    } ex_op_e;

    // second operand comes from reg_t_value or from the immediate
    typedef enum logic {
        OPTYPE_R,
        OPTYPE_I
    } op_type_e;

    typedef enum logic [1:0] {
        ACCESS_D2R,
        ACCESS_M2R,
        ACCESS_R2M
    } mem_op_e;

    typedef enum logic [1:0] {
        ACCESS_SZ_BYTE,
        ACCESS_SZ_HALF,
        ACCESS_SZ_WORD
    } mem_sz_e;

    // one decoded instruction with its register values already read
    typedef struct packed {
        ex_op_e      op;
        op_type_e    op_type;
        logic        flag_unsigned;
        logic [4:0]  reg_s;
        logic [4:0]  reg_t;
        logic [4:0]  reg_d;
        logic [31:0] reg_s_value;
        logic [31:0] reg_t_value;
        logic [15:0] immediate;
    } ex_req_t;

    typedef struct packed {
        mem_op_e     mem_op;
        mem_sz_e     mem_sz;
        logic        flag_unsigned;
        logic [31:0] mem_addr;
        logic [31:0] data;
        logic [4:0]  reg_addr;
        logic        overflow;
    } ex_res_t;

    typedef struct packed {
        logic [4:0]  reg_addr;
        logic [31:0] data;
        logic        overflow;
    } wb_res_t;

endpackage

// File: verilog/ex_issue.sv
// module ex_issue: input credit buffer and output credit counter, one issue per cycle
`timescale 1ns/1ns
`include "mips_ex_defs.svh"

module ex_issue
    import mips_ex_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n_i,
    input  logic    in_valid_i,
    input  ex_req_t in_req_i,
    output logic    in_credit_o,
    input  logic    out_credit_i,
    output logic    issue_valid_o,
    output ex_req_t issue_req_o
);

    localparam int PTR_W = (`IN_DEPTH > 1) ? $clog2(`IN_DEPTH) : 1;
    localparam int CNT_W = $clog2(`IN_DEPTH + 1);
    localparam int CRD_W = $clog2(`OUT_CREDITS + 1);

    ex_req_t            buf_q [`IN_DEPTH];
    logic [PTR_W-1:0]   wr_ptr_q;
    logic [PTR_W-1:0]   rd_ptr_q;
    logic [CNT_W-1:0]   count_q;
    logic [CRD_W-1:0]   credit_q;
    logic               push;
    logic               pop;

    // ##################################################
    // issue decision
    // ##################################################

    assign push = in_valid_i;

    // a credit in hand means the sink has room, so nothing stalls after this point
    assign pop = (count_q != '0) && (credit_q != '0);

    assign issue_valid_o = pop;
    assign issue_req_o   = buf_q[rd_ptr_q];
    assign in_credit_o   = pop;

    // ##################################################
    // circular buffer
    // ##################################################

    always_ff @(posedge clk) begin
        if (push) begin
            buf_q[wr_ptr_q] <= in_req_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(`IN_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(`IN_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // spending and returning a credit in the same cycle leaves the count alone
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            credit_q <= CRD_W'(`OUT_CREDITS);
        end else begin
            case ({pop, out_credit_i})
                2'b10:   credit_q <= credit_q - 1'b1;
                2'b01:   credit_q <= credit_q + 1'b1;
                default: credit_q <= credit_q;
            endcase
        end
    end

    // the source pushed without holding a credit
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n_i)
        push |-> (count_q != CNT_W'(`IN_DEPTH)));

    // the sink returned more credits than records it was sent
    a_credit_max: assert property (@(posedge clk) disable iff (!rst_n_i)
        credit_q <= CRD_W'(`OUT_CREDITS));

endmodule

// File: verilog/ex_alu.sv
// module ex_alu: combinational execute block with multiplier, overflow check and address generation
`timescale 1ns/1ns

module ex_alu
    import mips_ex_pkg::*;
(
    input  ex_req_t     req_i,
    input  logic [63:0] hilo_i,
    output ex_res_t     res_o,
    output logic        hilo_we_o,
    output logic [63:0] hilo_o
);

    logic [31:0] a;
    logic [31:0] t;
    logic [31:0] sign_ext_imm;
    logic [31:0] zero_ext_imm;
    logic [31:0] arith_b;
    logic [31:0] logic_b;
    logic [31:0] sum;
    logic [31:0] diff;
    logic        add_ovf;
    logic        sub_ovf;
    logic        less;
    logic [4:0]  shamt_imm;
    logic [4:0]  shamt_var;
    logic [63:0] mul_a;
    logic [63:0] mul_b;
    logic [63:0] product;
    logic [31:0] eff_addr;
    logic [4:0]  alu_dest;

    assign a = req_i.reg_s_value;
    assign t = req_i.reg_t_value;

    assign sign_ext_imm = {{16{req_i.immediate[15]}}, req_i.immediate};
    assign zero_ext_imm = {16'b0, req_i.immediate};

    // arithmetic takes a sign-extended immediate, logic ops a zero-extended one
    assign arith_b = (req_i.op_type == OPTYPE_R) ? t : sign_ext_imm;
    assign logic_b = (req_i.op_type == OPTYPE_R) ? t : zero_ext_imm;

    assign sum  = a + arith_b;
    assign diff = a - arith_b;

    assign add_ovf = !req_i.flag_unsigned && (a[31] == arith_b[31]) && (sum[31] != a[31]);
    assign sub_ovf = !req_i.flag_unsigned && (a[31] != arith_b[31]) && (diff[31] != a[31]);

    assign less = req_i.flag_unsigned ? (a < arith_b) : ($signed(a) < $signed(arith_b));

    assign shamt_imm = req_i.immediate[4:0];
    assign shamt_var = a[4:0];

    // the low 64 bits of a product of extended operands are right for both signednesses
    assign mul_a   = req_i.flag_unsigned ? {32'b0, a} : {{32{a[31]}}, a};
    assign mul_b   = req_i.flag_unsigned ? {32'b0, t} : {{32{t[31]}}, t};
    assign product = mul_a * mul_b;

    assign eff_addr = a + sign_ext_imm;
    assign alu_dest = (req_i.op_type == OPTYPE_R) ? req_i.reg_d : req_i.reg_t;

    // ##################################################
    // result select
    // ##################################################

    always_comb begin
        res_o               = '0;
        res_o.mem_op        = ACCESS_D2R;
        res_o.mem_sz        = ACCESS_SZ_WORD;
        res_o.flag_unsigned = req_i.flag_unsigned;
        hilo_we_o           = 1'b0;
        hilo_o              = hilo_i;

        case (req_i.op)
            OP_ADD: begin
                if (add_ovf) begin
                    res_o.overflow = 1'b1;
                end else begin
                    res_o.data     = sum;
                    res_o.reg_addr = alu_dest;
                end
            end
            OP_SUB: begin
                if (sub_ovf) begin
                    res_o.overflow = 1'b1;
                end else begin
                    res_o.data     = diff;
                    res_o.reg_addr = req_i.reg_d;
                end
            end
            OP_AND: begin
                res_o.data     = a & logic_b;
                res_o.reg_addr = alu_dest;
            end
            OP_OR: begin
                res_o.data     = a | logic_b;
                res_o.reg_addr = alu_dest;
            end
            OP_XOR: begin
                res_o.data     = a ^ logic_b;
                res_o.reg_addr = alu_dest;
            end
            OP_NOR: begin
                res_o.data     = ~(a | t);
                res_o.reg_addr = req_i.reg_d;
            end
            OP_SLT: begin
                res_o.data     = {31'b0, less};
                res_o.reg_addr = alu_dest;
            end
            OP_SLL: begin
                res_o.data     = t << shamt_imm;
                res_o.reg_addr = req_i.reg_d;
            end
            OP_SRL: begin
                res_o.data     = t >> shamt_imm;
                res_o.reg_addr = req_i.reg_d;
            end
            OP_SRA: begin
                res_o.data     = $signed(t) >>> shamt_imm;
                res_o.reg_addr = req_i.reg_d;
            end
            OP_SLLV: begin
                res_o.data     = t << shamt_var;
                res_o.reg_addr = req_i.reg_d;
            end
            OP_SRLV: begin
                res_o.data     = t >> shamt_var;
                res_o.reg_addr = req_i.reg_d;
            end
            OP_SRAV: begin
                res_o.data     = $signed(t) >>> shamt_var;
                res_o.reg_addr = req_i.reg_d;
            end
            OP_LU: begin
                res_o.data     = {req_i.immediate, 16'b0};
                res_o.reg_addr = req_i.reg_t;
            end
            OP_MUL: begin
                res_o.data     = product[31:0];
                res_o.reg_addr = req_i.reg_d;
            end
            OP_MULT: begin
                hilo_o    = product;
                hilo_we_o = 1'b1;
            end
            OP_MFHI: begin
                res_o.data     = hilo_i[63:32];
                res_o.reg_addr = req_i.reg_d;
            end
            OP_MFLO: begin
                res_o.data     = hilo_i[31:0];
                res_o.reg_addr = req_i.reg_d;
            end
            OP_MTHI: begin
                hilo_o    = {a, hilo_i[31:0]};
                hilo_we_o = 1'b1;
            end
            OP_MTLO: begin
                hilo_o    = {hilo_i[63:32], a};
                hilo_we_o = 1'b1;
            end
            // a move that is not taken writes nothing, so register 0 stays
            OP_MOVN: begin
                if (t != 32'b0) begin
                    res_o.data     = a;
                    res_o.reg_addr = req_i.reg_d;
                end
            end
            OP_MOVZ: begin
                if (t == 32'b0) begin
                    res_o.data     = a;
                    res_o.reg_addr = req_i.reg_d;
                end
            end
            OP_LB, OP_LH, OP_LW: begin
                res_o.mem_op   = ACCESS_M2R;
                res_o.mem_addr = eff_addr;
                res_o.reg_addr = req_i.reg_t;
            end
            OP_SB, OP_SH, OP_SW: begin
                res_o.mem_op   = ACCESS_R2M;
                res_o.mem_addr = eff_addr;
                res_o.data     = t;
            end
            default: begin
                res_o.data = 32'b0;
            end
        endcase

        case (req_i.op)
            OP_LB, OP_SB: res_o.mem_sz = ACCESS_SZ_BYTE;
            OP_LH, OP_SH: res_o.mem_sz = ACCESS_SZ_HALF;
            default:      res_o.mem_sz = ACCESS_SZ_WORD;
        endcase
    end

endmodule

// File: verilog/ex_stage.sv
// module ex_stage: execute pipeline stage holding HI/LO and the registered ex_alu result
`timescale 1ns/1ns

module ex_stage
    import mips_ex_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n_i,
    input  logic    issue_valid_i,
    input  ex_req_t issue_req_i,
    output logic    ex_valid_o,
    output ex_res_t ex_res_o
);

    logic [63:0] hilo_q;
    logic [63:0] hilo_next;
    logic        hilo_we;
    ex_res_t     alu_res;

    ex_alu u_ex_alu (
        .req_i     (issue_req_i),
        .hilo_i    (hilo_q),
        .res_o     (alu_res),
        .hilo_we_o (hilo_we),
        .hilo_o    (hilo_next)
    );

    // HI/LO is read and written here, so MFHI/MFLO always see the latest MULT or MTxx
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hilo_q     <= 64'b0;
            ex_valid_o <= 1'b0;
        end else begin
            ex_valid_o <= issue_valid_i;
            if (issue_valid_i && hilo_we) begin
                hilo_q <= hilo_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid_i) begin
            ex_res_o <= alu_res;
        end
    end

    a_hilo_source: assert property (@(posedge clk) disable iff (!rst_n_i)
        (hilo_q != $past(hilo_q)) |->
            $past(issue_valid_i && (issue_req_i.op inside {OP_MULT, OP_MTHI, OP_MTLO})));

endmodule

// File: verilog/mem_stage.sv
// mem_stage module with data memory, store byte merge, load extension and the writeback register
`timescale 1ns/1ns
`include "mips_ex_defs.svh"

module mem_stage
    import mips_ex_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n_i,
    input  logic    ex_valid_i,
    input  ex_res_t ex_res_i,
    output logic    out_valid_o,
    output wb_res_t out_res_o
);

    localparam int IDX_W = $clog2(`DMEM_WORDS);

    logic [31:0]      dmem_q [`DMEM_WORDS];
    logic [IDX_W-1:0] word_idx;
    logic [1:0]       lane;
    logic [31:0]      rd_word;
    logic [31:0]      wr_data;
    logic [3:0]       byte_en;
    logic [31:0]      merged;
    logic [7:0]       ld_byte;
    logic [15:0]      ld_half;
    logic [31:0]      ld_data;
    logic             store_we;

    // upper address bits are dropped, so the index wraps within the memory
    assign word_idx = ex_res_i.mem_addr[IDX_W+1:2];
    assign lane     = ex_res_i.mem_addr[1:0];
    assign rd_word  = dmem_q[word_idx];
    assign store_we = ex_valid_i && (ex_res_i.mem_op == ACCESS_R2M);

    // ##################################################
    // little-endian store lanes
    // ##################################################

    always_comb begin
        case (ex_res_i.mem_sz)
            ACCESS_SZ_BYTE: begin
                wr_data = {4{ex_res_i.data[7:0]}};
                byte_en = 4'b0001 << lane;
            end
            ACCESS_SZ_HALF: begin
                wr_data = {2{ex_res_i.data[15:0]}};
                byte_en = lane[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                wr_data = ex_res_i.data;
                byte_en = 4'b1111;
            end
        endcase
        for (int i = 0; i < 4; i++) begin
            merged[8*i +: 8] = byte_en[i] ? wr_data[8*i +: 8] : rd_word[8*i +: 8];
        end
    end

    // loads zero-fill instead of sign-extending when flag_unsigned is set
    assign ld_byte = rd_word[{lane, 3'b000} +: 8];
    assign ld_half = lane[1] ? rd_word[31:16] : rd_word[15:0];

    always_comb begin
        case (ex_res_i.mem_sz)
            ACCESS_SZ_BYTE: ld_data = {{24{ld_byte[7] & ~ex_res_i.flag_unsigned}}, ld_byte};
            ACCESS_SZ_HALF: ld_data = {{16{ld_half[15] & ~ex_res_i.flag_unsigned}}, ld_half};
            default:        ld_data = rd_word;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `DMEM_WORDS; i++) begin
                dmem_q[i] <= 32'b0;
            end
        end else if (store_we) begin
            dmem_q[word_idx] <= merged;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_valid_o <= 1'b0;
        end else begin
            out_valid_o <= ex_valid_i;
        end
    end

    // a store only writes memory, so its record is register 0 with data 0
    always_ff @(posedge clk) begin
        if (ex_valid_i) begin
            out_res_o.reg_addr <= ex_res_i.reg_addr;
            out_res_o.data     <= (ex_res_i.mem_op == ACCESS_M2R) ? ld_data :
                                  (ex_res_i.mem_op == ACCESS_R2M) ? 32'b0 : ex_res_i.data;
            out_res_o.overflow <= ex_res_i.overflow;
        end
    end

    // ex_alu must hand every memory access a real size
    a_mem_size: assert property (@(posedge clk) disable iff (!rst_n_i)
        (ex_valid_i && (ex_res_i.mem_op inside {ACCESS_M2R, ACCESS_R2M})) |->
            (ex_res_i.mem_sz inside {ACCESS_SZ_BYTE, ACCESS_SZ_HALF, ACCESS_SZ_WORD}));

endmodule

// File: verilog/mips_ex_top.sv
// module mips_ex_top: issue, execute and memory stages joined to the credit ports
`timescale 1ns/1ns

module mips_ex_top
    import mips_ex_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n_i,
    input  logic    in_valid_i,
    input  ex_req_t in_req_i,
    output logic    in_credit_o,
    output logic    out_valid_o,
    output wb_res_t out_res_o,
    input  logic    out_credit_i
);

    logic    issue_valid;
    ex_req_t issue_req;
    logic    ex_valid;
    ex_res_t ex_res;

    ex_issue u_ex_issue (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .in_valid_i    (in_valid_i),
        .in_req_i      (in_req_i),
        .in_credit_o   (in_credit_o),
        .out_credit_i  (out_credit_i),
        .issue_valid_o (issue_valid),
        .issue_req_o   (issue_req)
    );

    ex_stage u_ex_stage (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .issue_valid_i (issue_valid),
        .issue_req_i   (issue_req),
        .ex_valid_o    (ex_valid),
        .ex_res_o      (ex_res)
    );

    mem_stage u_mem_stage (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .ex_valid_i  (ex_valid),
        .ex_res_i    (ex_res),
        .out_valid_o (out_valid_o),
        .out_res_o   (out_res_o)
    );

endmodule

// File: bench/mips_ex_tb.sv
// mips_ex_tb testbench with stimulus table, credit source, credit-returning sink and compare tasks
`timescale 1ns/1ns
`include "mips_ex_defs.svh"

module mips_ex_tb
    import mips_ex_pkg::*;
();

    localparam int         WAIT_LIMIT = 400;
    localparam logic [4:0] R0 = 5'd0;
    localparam logic [4:0] RT = 5'd2;
    localparam logic [4:0] RD = 5'd3;

    logic    clk;
    logic    rst_n_i;
    logic    in_valid_i;
    ex_req_t in_req_i;
    logic    in_credit_o;
    logic    out_valid_o;
    wb_res_t out_res_o;
    logic    out_credit_i = 1'b0;

    ex_req_t req_q[$];
    wb_res_t exp_q[$];
    int      delay_q[$];
    int      keep_q[$];

    int dut_credits     = `OUT_CREDITS;
    int ready_credits   = 0;
    int got_count       = 0;
    int in_credit_total = 0;
    int check_errors    = 0;
    int flow_errors     = 0;
    int timeouts        = 0;

    mips_ex_top DUT (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .in_valid_i   (in_valid_i),
        .in_req_i     (in_req_i),
        .in_credit_o  (in_credit_o),
        .out_valid_o  (out_valid_o),
        .out_res_o    (out_res_o),
        .out_credit_i (out_credit_i)
    );

    always #50 clk = ~clk;

    // ##################################################
    // compare tasks
    // ##################################################

    // fields are shown as reg/data/overflow
    task automatic check_wb(input string name, input wb_res_t got, input wb_res_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s got %0d/%h/%b expected %0d/%h/%b",
                     $time, name, got.reg_addr, got.data, got.overflow,
                     exp.reg_addr, exp.data, exp.overflow);
            check_errors++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("CHECK FAILED at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
            check_errors++;
        end
    endtask

    // ##################################################
    // stimulus table
    // ##################################################

    // reg_s, reg_t and reg_d are always 1, 2 and 3
    task automatic add_vec(input ex_op_e op, input op_type_e ty, input logic fu,
                           input logic [31:0] s_val, input logic [31:0] t_val,
                           input logic [15:0] imm, input logic [4:0] exp_reg,
                           input logic [31:0] exp_data, input logic exp_ovf);
        ex_req_t req;
        wb_res_t exp;
        req               = '0;
        req.op            = op;
        req.op_type       = ty;
        req.flag_unsigned = fu;
        req.reg_s         = 5'd1;
        req.reg_t         = RT;
        req.reg_d         = RD;
        req.reg_s_value   = s_val;
        req.reg_t_value   = t_val;
        req.immediate     = imm;
        exp.reg_addr      = exp_reg;
        exp.data          = exp_data;
        exp.overflow      = exp_ovf;
        req_q.push_back(req);
        exp_q.push_back(exp);
    endtask

    task automatic fill_table();
        add_vec(OP_ADD,  OPTYPE_R, 0, 32'h00000005, 32'h00000007, 16'h0000, RD, 32'h0000000c, 0);
        add_vec(OP_ADD,  OPTYPE_I, 0, 32'h00000010, 32'h00000000, 16'hffff, RT, 32'h0000000f, 0);
        add_vec(OP_SUB,  OPTYPE_R, 0, 32'h00000010, 32'h00000018, 16'h0000, RD, 32'hfffffff8, 0);
        add_vec(OP_AND,  OPTYPE_R, 0, 32'hf0f0f0f0, 32'hff00ff00, 16'h0000, RD, 32'hf000f000, 0);
        add_vec(OP_AND,  OPTYPE_I, 0, 32'h1234abcd, 32'h00000000, 16'hff00, RT, 32'h0000ab00, 0);
        add_vec(OP_OR,   OPTYPE_R, 0, 32'h000000f0, 32'h0000000f, 16'h0000, RD, 32'h000000ff, 0);
        add_vec(OP_OR,   OPTYPE_I, 0, 32'h12340000, 32'h00000000, 16'h8001, RT, 32'h12348001, 0);
        add_vec(OP_XOR,  OPTYPE_R, 0, 32'hffff0000, 32'h0f0f0f0f, 16'h0000, RD, 32'hf0f00f0f, 0);
        add_vec(OP_XOR,  OPTYPE_I, 0, 32'h0000ffff, 32'h00000000, 16'h00ff, RT, 32'h0000ff00, 0);
        add_vec(OP_NOR,  OPTYPE_R, 0, 32'h0000f0f0, 32'h00000f0f, 16'h0000, RD, 32'hffff0000, 0);
        add_vec(OP_SLT,  OPTYPE_R, 0, 32'hffffffff, 32'h00000001, 16'h0000, RD, 32'h00000001, 0);
        add_vec(OP_SLT,  OPTYPE_R, 1, 32'hffffffff, 32'h00000001, 16'h0000, RD, 32'h00000000, 0);
        add_vec(OP_SLT,  OPTYPE_I, 0, 32'hfffffff0, 32'h00000000, 16'hfffe, RT, 32'h00000001, 0);
        add_vec(OP_SLT,  OPTYPE_I, 1, 32'h00000005, 32'h00000000, 16'hffff, RT, 32'h00000001, 0);
        add_vec(OP_LU,   OPTYPE_I, 0, 32'h00000000, 32'h00000000, 16'hbeef, RT, 32'hbeef0000, 0);
        add_vec(OP_MOVN, OPTYPE_R, 0, 32'hcafe0001, 32'h00000001, 16'h0000, RD, 32'hcafe0001, 0);
        add_vec(OP_MOVN, OPTYPE_R, 0, 32'hcafe0001, 32'h00000000, 16'h0000, R0, 32'h00000000, 0);
        add_vec(OP_MOVZ, OPTYPE_R, 0, 32'h00000042, 32'h00000000, 16'h0000, RD, 32'h00000042, 0);
        add_vec(OP_MOVZ, OPTYPE_R, 0, 32'h00000042, 32'h00000005, 16'h0000, R0, 32'h00000000, 0);
        // signed overflow, then the same operands as unsigned
        add_vec(OP_ADD,  OPTYPE_R, 0, 32'h7fffffff, 32'h00000001, 16'h0000, R0, 32'h00000000, 1);
        add_vec(OP_ADD,  OPTYPE_R, 1, 32'h7fffffff, 32'h00000001, 16'h0000, RD, 32'h80000000, 0);
        add_vec(OP_SUB,  OPTYPE_R, 0, 32'h80000000, 32'h00000001, 16'h0000, R0, 32'h00000000, 1);
        add_vec(OP_SUB,  OPTYPE_R, 1, 32'h80000000, 32'h00000001, 16'h0000, RD, 32'h7fffffff, 0);
        add_vec(OP_ADD,  OPTYPE_I, 0, 32'h7ffffff0, 32'h00000000, 16'h0010, R0, 32'h00000000, 1);
        // bit 5 of the SRA immediate and of the SLLV amount is ignored by the shifts
        add_vec(OP_SLL,  OPTYPE_R, 0, 32'h00000000, 32'h00000003, 16'h0004, RD, 32'h00000030, 0);
        add_vec(OP_SRL,  OPTYPE_R, 0, 32'h00000000, 32'h80000000, 16'h001f, RD, 32'h00000001, 0);
        add_vec(OP_SRA,  OPTYPE_R, 0, 32'h00000000, 32'h80000000, 16'h0024, RD, 32'hf8000000, 0);
        add_vec(OP_SLLV, OPTYPE_R, 0, 32'h00000028, 32'h000000ff, 16'h0000, RD, 32'h0000ff00, 0);
        add_vec(OP_SRLV, OPTYPE_R, 0, 32'h00000010, 32'habcd1234, 16'h0000, RD, 32'h0000abcd, 0);
        add_vec(OP_SRAV, OPTYPE_R, 0, 32'h00000008, 32'h87654321, 16'h0000, RD, 32'hff876543, 0);
        // multiply and HI/LO
        add_vec(OP_MUL,  OPTYPE_R, 0, 32'hfffffffe, 32'h00000003, 16'h0000, RD, 32'hfffffffa, 0);
        add_vec(OP_MULT, OPTYPE_R, 0, 32'hfffffffe, 32'h00000003, 16'h0000, R0, 32'h00000000, 0);
        add_vec(OP_MFHI, OPTYPE_R, 0, 32'h00000000, 32'h00000000, 16'h0000, RD, 32'hffffffff, 0);
        add_vec(OP_MFLO, OPTYPE_R, 0, 32'h00000000, 32'h00000000, 16'h0000, RD, 32'hfffffffa, 0);
        add_vec(OP_MULT, OPTYPE_R, 1, 32'hfffffffe, 32'h00000003, 16'h0000, R0, 32'h00000000, 0);
        add_vec(OP_MFHI, OPTYPE_R, 0, 32'h00000000, 32'h00000000, 16'h0000, RD, 32'h00000002, 0);
        add_vec(OP_MFLO, OPTYPE_R, 0, 32'h00000000, 32'h00000000, 16'h0000, RD, 32'hfffffffa, 0);
        add_vec(OP_MTHI, OPTYPE_R, 0, 32'h11112222, 32'h00000000, 16'h0000, R0, 32'h00000000, 0);
        add_vec(OP_MTLO, OPTYPE_R, 0, 32'h33334444, 32'h00000000, 16'h0000, R0, 32'h00000000, 0);
        add_vec(OP_MFHI, OPTYPE_R, 0, 32'h00000000, 32'h00000000, 16'h0000, RD, 32'h11112222, 0);
        add_vec(OP_MFLO, OPTYPE_R, 0, 32'h00000000, 32'h00000000, 16'h0000, RD, 32'h33334444, 0);
        // store records carry register 0 and data 0 and leave word 16 as abcdee44
        add_vec(OP_SW,   OPTYPE_I, 0, 32'h00000040, 32'h11223344, 16'h0000, R0, 32'h00000000, 0);
        add_vec(OP_SH,   OPTYPE_I, 0, 32'h00000040, 32'h0000abcd, 16'h0002, R0, 32'h00000000, 0);
        add_vec(OP_SB,   OPTYPE_I, 0, 32'h00000044, 32'h000000ee, 16'hfffd, R0, 32'h00000000, 0);
        add_vec(OP_LW,   OPTYPE_I, 0, 32'h00000040, 32'h00000000, 16'h0000, RT, 32'habcdee44, 0);
        add_vec(OP_LH,   OPTYPE_I, 0, 32'h00000040, 32'h00000000, 16'h0002, RT, 32'hffffabcd, 0);
        add_vec(OP_LH,   OPTYPE_I, 1, 32'h00000040, 32'h00000000, 16'h0002, RT, 32'h0000abcd, 0);
        add_vec(OP_LB,   OPTYPE_I, 0, 32'h00000040, 32'h00000000, 16'h0001, RT, 32'hffffffee, 0);
        add_vec(OP_LB,   OPTYPE_I, 1, 32'h00000040, 32'h00000000, 16'h0001, RT, 32'h000000ee, 0);
        add_vec(OP_LB,   OPTYPE_I, 0, 32'h00000040, 32'h00000000, 16'h0000, RT, 32'h00000044, 0);
        add_vec(OP_LH,   OPTYPE_I, 0, 32'h00000040, 32'h00000000, 16'h0000, RT, 32'hffffee44, 0);
        add_vec(OP_LW,   OPTYPE_I, 0, 32'h00000100, 32'h00000000, 16'h0040, RT, 32'habcdee44, 0);
        add_vec(OP_NOP,  OPTYPE_R, 0, 32'h12345678, 32'h9abcdef0, 16'h0000, R0, 32'h00000000, 0);
    endtask

    // ##################################################
    // source, sink and credit monitor
    // ##################################################

    // the source spends a credit per valid cycle and gets one back per in_credit_o pulse
    task automatic send_all();
        int idx;
        int credits;
        int idle;
        idx     = 0;
        credits = `IN_DEPTH;
        idle    = 0;
        while (idx < req_q.size() && timeouts == 0) begin
            @(posedge clk);
            if (in_credit_o) begin
                credits++;
            end
            if (credits > 0) begin
                in_valid_i <= 1'b1;
                in_req_i   <= req_q[idx];
                credits--;
                idx++;
                idle = 0;
            end else begin
                in_valid_i <= 1'b0;
                idle++;
                if (idle > WAIT_LIMIT) begin
                    $display("timeout: no input credit came back for request %0d", idx);
                    timeouts++;
                end
            end
        end
        @(posedge clk);
        in_valid_i <= 1'b0;
    endtask

    always @(posedge clk) begin
        if (rst_n_i && in_credit_o) begin
            in_credit_total <= in_credit_total + 1;
        end
    end

    always @(posedge clk) begin
        if (!rst_n_i) begin
            out_credit_i <= 1'b0;
        end else begin
            if (out_credit_i) begin
                dut_credits++;
            end
            if (out_valid_o) begin
                if (dut_credits == 0) begin
                    $display("out_valid_o was high at %0t ns while the DUT held no credits",
                             $time);
                    flow_errors++;
                end else begin
                    dut_credits--;
                end
                if (got_count < exp_q.size()) begin
                    check_wb($sformatf("out_res_o[%0d]", got_count), out_res_o,
                             exp_q[got_count]);
                end else begin
                    $display("an extra record arrived at %0t ns after the last one", $time);
                    flow_errors++;
                end
                got_count++;
                delay_q.push_back(int'($urandom % 6));
            end
            keep_q.delete();
            foreach (delay_q[i]) begin
                if (delay_q[i] == 0) begin
                    ready_credits++;
                end else begin
                    keep_q.push_back(delay_q[i] - 1);
                end
            end
            delay_q = keep_q;
            if (ready_credits > 0) begin
                out_credit_i <= 1'b1;
                ready_credits--;
            end else begin
                out_credit_i <= 1'b0;
            end
        end
    end

    // ##################################################
    // wait loops
    // ##################################################

    task automatic wait_records();
        int cycles;
        cycles = 0;
        while (got_count < exp_q.size() && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (got_count < exp_q.size()) begin
            $display("timeout: only %0d of %0d records came out", got_count, exp_q.size());
            timeouts++;
        end
    endtask

    task automatic wait_sink_idle();
        int cycles;
        cycles = 0;
        while ((dut_credits != `OUT_CREDITS || delay_q.size() != 0) && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (dut_credits != `OUT_CREDITS) begin
            $display("timeout: the sink never returned all of its credits");
            timeouts++;
        end
    endtask

    task automatic wait_in_credits();
        int cycles;
        cycles = 0;
        while (in_credit_total < req_q.size() && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (in_credit_total < req_q.size()) begin
            $display("timeout: only %0d input credits came back", in_credit_total);
            timeouts++;
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst_n_i    = 1'b0;
        in_valid_i = 1'b0;
        in_req_i   = '0;
        void'($urandom(32'h3400_7a39));
        fill_table();
        repeat (8) @(posedge clk);
        rst_n_i <= 1'b1;
        send_all();
        if (timeouts == 0) begin
            wait_records();
        end
        if (timeouts == 0) begin
            wait_sink_idle();
        end
        if (timeouts == 0) begin
            wait_in_credits();
            check_count("records received", got_count, exp_q.size());
            check_count("in_credit_o pulses", in_credit_total, req_q.size());
        end
        $display("errors: %0d compare, %0d flow control, %0d timeout",
                 check_errors, flow_errors, timeouts);
        if (check_errors + flow_errors + timeouts == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: mips_ex.f
+incdir+include
verilog/mips_ex_pkg.sv
verilog/ex_issue.sv
verilog/ex_alu.sv
verilog/ex_stage.sv
verilog/mem_stage.sv
verilog/mips_ex_top.sv
bench/mips_ex_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = mips_ex_tb
FILELIST = mips_ex.f
LOG      = sim.log

SOURCES  = $(filter %.sv %.v,$(shell cat $(FILELIST)))
HEADERS  = $(wildcard include/*.svh)
BIN      = obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@grep -q "Simulation passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
